/* dv/snakeArenaChecker.sv */
`timescale 1ns/1ps

module snakeArenaChecker import snakeArenaPkg::*; (
	input  logic        vga_clk,
	input  logic        checkEn,
	input  int          testId,
	input  logic [11:0] expRgb,
	input  healthT      expHealth,
	input  logic        expWon,
	input  logic [3:0]  red,
	input  logic [3:0]  green,
	input  logic [3:0]  blue,
	input  healthT      snake2Health,
	input  logic        snake1Won,
	output int          passCount,
	output int          failCount,
	output int          checkedCount
);

	initial begin
		passCount = 0;
		failCount = 0;
		checkedCount = 0;
	end

	// outputs settle right after the rising edge, sample mid cycle
	always @(negedge vga_clk) begin
		if (checkEn) begin
			if ({red, green, blue} !== expRgb || snake2Health !== expHealth ||
				snake1Won !== expWon) begin
				$display("ERROR at %0t: test %0d got rgb %h health %0d won %b, want %h %0d %b",
					$time, testId, {red, green, blue}, snake2Health, snake1Won,
					expRgb, expHealth, expWon);
				failCount = failCount + 1;
			end else begin
				$display("test %0d ok: rgb %h health %0d won %b", testId, expRgb,
					expHealth, expWon);
				passCount = passCount + 1;
			end
			checkedCount = checkedCount + 1;
		end
	end

	task printSummary();
		$display("checks done: %0d passed, %0d failed", passCount, failCount);
	endtask

endmodule

/* dv/snakeArenaTb.sv */
`timescale 1ns/1ps

module snakeArenaTb import snakeArenaPkg::*; ();

	// one stimulus row, expected values describe the state after its clock edge
	typedef struct packed {
		coordT       x;
		coordT       y;
		logic        blank;
		coordT       s2X;
		coordT       vX;
		coordT       vY;
		coordT       vR;
		logic        vAct;
		logic [11:0] bg;
		logic [11:0] s1p;
		logic [11:0] expRgb;
		healthT      expHealth;
		logic        expWon;
	} rowT;

	localparam logic [11:0] BG = 12'h123;
	localparam logic [11:0] S1 = 12'h4A6;
	localparam logic [11:0] S2 = 12'h58C;

	logic vga_clk;
	logic rstN;
	coordT drawX;
	coordT drawY;
	logic blank;
	coordT snake1X;
	coordT snake1Y;
	coordT snake2X;
	coordT snake2Y;
	coordT venomX [3];
	coordT venomY [3];
	coordT venomR [3];
	logic [2:0] venomActive;
	pixelColor bgPixel;
	pixelColor snake1Pixel;
	pixelColor snake2Pixel;
	logic [3:0] red;
	logic [3:0] green;
	logic [3:0] blue;
	healthT snake2Health;
	logic snake1Won;

	logic checkEn;
	int testId;
	logic [11:0] expRgb;
	healthT expHealth;
	logic expWon;
	int passCount;
	int failCount;
	int checkedCount;

	rowT rows[$];
	int seed;

	snakeArenaTop #(.NUM_VENOMS(3), .MAX_HEALTH(3)) i_dut (
		.vga_clk(vga_clk), .rstN(rstN), .drawX(drawX), .drawY(drawY), .blank(blank),
		.snake1X(snake1X), .snake1Y(snake1Y), .snake2X(snake2X), .snake2Y(snake2Y),
		.venomX(venomX), .venomY(venomY), .venomR(venomR), .venomActive(venomActive),
		.bgPixel(bgPixel), .snake1Pixel(snake1Pixel), .snake2Pixel(snake2Pixel),
		.red(red), .green(green), .blue(blue),
		.snake2Health(snake2Health), .snake1Won(snake1Won)
	);

	snakeArenaChecker i_checker (
		.vga_clk(vga_clk), .checkEn(checkEn), .testId(testId),
		.expRgb(expRgb), .expHealth(expHealth), .expWon(expWon),
		.red(red), .green(green), .blue(blue),
		.snake2Health(snake2Health), .snake1Won(snake1Won),
		.passCount(passCount), .failCount(failCount), .checkedCount(checkedCount)
	);

	initial begin
		vga_clk = 1'b0;
		forever #2 vga_clk = ~vga_clk;
	end

	// snake 1 fixed at (100,100), snake 2 at (s2X,100), only venom 0 used
	task addRow(input int x, input int y, input logic bl, input int s2x, input int vx,
		input int vy, input int vr, input logic va, input logic [11:0] bg,
		input logic [11:0] s1p, input logic [11:0] rgb, input int h, input logic w);
		rowT r;
		r = '{coordT'(x), coordT'(y), bl, coordT'(s2x), coordT'(vx), coordT'(vy),
			coordT'(vr), va, bg, s1p, rgb, healthT'(h), w};
		rows.push_back(r);
	endtask

	task applyRow(input rowT r);
		drawX = r.x;
		drawY = r.y;
		blank = r.blank;
		snake2X = r.s2X;
		venomX[0] = r.vX;
		venomY[0] = r.vY;
		venomR[0] = r.vR;
		venomActive = {2'b00, r.vAct};
		bgPixel.raw = r.bg;
		snake1Pixel.raw = r.s1p;
	endtask

	// one venom hit on snake 2, then the frame-start pixel that takes the life
	task addHitFrame(input int h, input logic w);
		addRow(300, 100, 1, 300, 300, 100, 5, 1, BG, S1, 12'h000, h + 1, 1'b0);
		addRow(0, 0, 1, 300, 0, 0, 0, 0, BG, S1, BG, h, w);
	endtask

	task buildTable();
		logic [11:0] rbg;
		logic rbl;
		// blank forces black even over snake 1
		addRow(100, 100, 0, 300, 0, 0, 0, 0, BG, S1, 12'h000, 3, 0);
		// head box centre, edges and just outside
		addRow(100, 100, 1, 300, 0, 0, 0, 0, BG, S1, S1, 3, 0);
		addRow(88, 100, 1, 300, 0, 0, 0, 0, BG, S1, S1, 3, 0);
		addRow(111, 111, 1, 300, 0, 0, 0, 0, BG, S1, S1, 3, 0);
		addRow(112, 100, 1, 300, 0, 0, 0, 0, BG, S1, BG, 3, 0);
		addRow(87, 100, 1, 300, 0, 0, 0, 0, BG, S1, BG, 3, 0);
		addRow(100, 87, 1, 300, 0, 0, 0, 0, BG, S1, BG, 3, 0);
		// transparency key shows the background
		addRow(100, 100, 1, 300, 0, 0, 0, 0, BG, 12'hF0F, BG, 3, 0);
		// overlapping heads, snake 1 on top, key lets snake 2 through
		addRow(105, 100, 1, 110, 0, 0, 0, 0, BG, S1, S1, 3, 0);
		addRow(105, 100, 1, 110, 0, 0, 0, 0, BG, 12'hF0F, S2, 3, 0);
		// venom rim, inactive venom, venom over snake 1
		addRow(210, 200, 1, 300, 200, 200, 10, 1, BG, S1, 12'h000, 3, 0);
		addRow(211, 200, 1, 300, 200, 200, 10, 1, BG, S1, BG, 3, 0);
		addRow(210, 200, 1, 300, 200, 200, 10, 0, BG, S1, BG, 3, 0);
		addRow(100, 100, 1, 300, 100, 100, 3, 1, BG, S1, 12'h000, 3, 0);
		// snake 1 hearts, corner, and over a venom
		addRow(13, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 3, 0);
		addRow(5, 462, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 3, 0);
		addRow(28, 470, 1, 300, 28, 470, 4, 1, BG, S1, 12'hF00, 3, 0);
		addRow(597, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 3, 0);
		// health steps down, hearts go out from the left
		addHitFrame(2, 0);
		addRow(597, 470, 1, 300, 0, 0, 0, 0, BG, S1, BG, 2, 0);
		addRow(612, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 2, 0);
		// a clean frame changes nothing
		addRow(400, 400, 1, 300, 0, 0, 0, 0, BG, S1, BG, 2, 0);
		addRow(0, 0, 1, 300, 0, 0, 0, 0, BG, S1, BG, 2, 0);
		addRow(612, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 2, 0);
		addHitFrame(1, 0);
		addRow(612, 470, 1, 300, 0, 0, 0, 0, BG, S1, BG, 1, 0);
		addRow(627, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 1, 0);
		addHitFrame(0, 1);
		addRow(627, 470, 1, 300, 0, 0, 0, 0, BG, S1, BG, 0, 1);
		addRow(13, 470, 1, 300, 0, 0, 0, 0, BG, S1, 12'hF00, 0, 1);
		// further hits keep health at zero
		addRow(300, 100, 1, 300, 300, 100, 5, 1, BG, S1, 12'h000, 0, 1);
		addRow(0, 0, 1, 300, 0, 0, 0, 0, BG, S1, BG, 0, 1);
		// random backgrounds on empty pixels
		for (int i = 0; i < 8; i++) begin
			rbg = $random(seed);
			rbl = $random(seed);
			addRow(400 + 7 * i, 50, rbl, 300, 0, 0, 0, 0, rbg, S1,
				rbl ? rbg : 12'h000, 0, 1);
		end
	endtask

	task waitChecked(input int n);
		int waited;
		waited = 0;
		while (checkedCount < n && waited < 50) begin
			@(posedge vga_clk);
			waited++;
		end
		if (checkedCount < n) begin
			$display("timed out waiting for the checker to finish all tests");
			$display("Something failed");
			$finish;
		end
	endtask

	// hard stop if the run hangs
	initial begin
		#20000;
		$display("simulation ran past its time limit");
		$display("Something failed");
		$finish;
	end

	initial begin
		seed = 32'h35d3;
		rstN = 1'b0;
		checkEn = 1'b0;
		testId = 0;
		expRgb = '0;
		expHealth = '0;
		expWon = 1'b0;
		snake1X = 10'd100;
		snake1Y = 10'd100;
		snake2Y = 10'd100;
		for (int v = 0; v < 3; v++) begin
			venomX[v] = '0;
			venomY[v] = '0;
			venomR[v] = '0;
		end
		snake2Pixel.raw = S2;
		buildTable();
		// visible snake 1 pixel while in reset, output must stay black
		applyRow(rows[1]);
		repeat (2) @(posedge vga_clk);
		#1;
		testId = 0;
		expRgb = '0;
		expHealth = healthT'(3);
		expWon = 1'b0;
		checkEn = 1'b1;
		@(posedge vga_clk);
		#1;
		checkEn = 1'b0;
		rstN = 1'b1;
		// row i driven, row i-1 checked in the same cycle
		for (int i = 0; i <= rows.size(); i++) begin
			@(posedge vga_clk);
			#1;
			if (i < rows.size()) begin
				applyRow(rows[i]);
			end
			if (i > 0) begin
				testId = i;
				expRgb = rows[i - 1].expRgb;
				expHealth = rows[i - 1].expHealth;
				expWon = rows[i - 1].expWon;
				checkEn = 1'b1;
			end
		end
		@(posedge vga_clk);
		#1 checkEn = 1'b0;
		waitChecked(rows.size() + 1);
		i_checker.printSummary();
		if (failCount == 0 && checkedCount == rows.size() + 1) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* dv/snakeArena_assertions.sv */
`timescale 1ns/1ps

module snakeArenaAssertions import snakeArenaPkg::*; (
	input logic       vga_clk,
	input logic       rstN,
	input logic       blank,
	input logic [3:0] red,
	input logic [3:0] green,
	input logic [3:0] blue,
	input healthT     snake2Health,
	input logic       snake1Won
);

	// black one pixel after the blanking interval
	blankBlack: assert property (@(posedge vga_clk) disable iff (!rstN)
		!blank |=> ({red, green, blue} == 12'h000))
		else $error("rgb not black after blank low");

	// lives only ever go down
	healthNoRise: assert property (@(posedge vga_clk) disable iff (!rstN)
		snake2Health <= $past(snake2Health))
		else $error("snake2Health rose");

	// win flag is sticky
	wonSticky: assert property (@(posedge vga_clk) disable iff (!rstN)
		$past(snake1Won) |-> snake1Won)
		else $error("snake1Won fell");

endmodule

bind snakeArenaTop snakeArenaAssertions i_assertions (
	.vga_clk(vga_clk), .rstN(rstN), .blank(blank),
	.red(red), .green(green), .blue(blue),
	.snake2Health(snake2Health), .snake1Won(snake1Won)
);

/* hw/healthTracker.sv */
`timescale 1ns/1ps

module healthTracker import snakeArenaPkg::*; #(
	parameter int MAX_HEALTH = 3
) (
	input  logic   vga_clk,
	input  logic   rstN,
	input  coordT  drawX,
	input  coordT  drawY,
	input  logic   snake2On,
	input  logic   venomOn,
	output healthT snake2Health,
	output logic   snake1Won
);

	logic hitLatch;
	logic hitNow;
	logic frameStart;

	// venom overlapping snake 2 on this pixel
	assign hitNow = snake2On && venomOn;

	// top left pixel opens a new frame
	assign frameStart = (drawX == '0) && (drawY == '0);

	// hit latch, collects every hit pixel of one frame
	// the frame-start pixel already belongs to the new frame
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			hitLatch <= 1'b0;
		end else if (frameStart) begin
			hitLatch <= hitNow;
		end else if (hitNow) begin
			hitLatch <= 1'b1;
		end
	end

	// one life per hit frame, applied at the next frame start
	// stuck at zero once reached
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			snake2Health <= healthT'(MAX_HEALTH);
		end else if (frameStart && hitLatch && (snake2Health != '0)) begin
			snake2Health <= snake2Health - 1'b1;
		end
	end

	// win flag, rises on the edge that takes the last life
	// sticky until reset
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			snake1Won <= 1'b0;
		end else if (frameStart && hitLatch && (snake2Health == healthT'(1))) begin
			snake1Won <= 1'b1;
		end
	end

endmodule

/* hw/heartOverlay.sv */
`timescale 1ns/1ps

module heartOverlay import snakeArenaPkg::*; #(
	parameter int MAX_HEALTH = 3
) (
	input  coordT  drawX,
	input  coordT  drawY,
	input  healthT snake2Health,
	output logic   heartOn
);

	// hearts per player, taken from the layout table
	localparam int NUM_HEARTS = $size(HEART1_X);

	logic [NUM_HEARTS-1:0] p1Heart;
	logic [NUM_HEARTS-1:0] p2Heart;

	// square box around one heart centre
	// margin added on the pixel side so nothing underflows
	function automatic logic inHeart(coordT px, coordT py, coordT cx);
		return (px + HEART_HALF >= cx) && (px <= cx + HEART_HALF) &&
			(py + HEART_HALF >= HEART_ROW_Y) && (py <= HEART_ROW_Y + HEART_HALF);
	endfunction

	for (genvar j = 0; j < NUM_HEARTS; j++) begin : gHeart
		// snake 1 never loses lives here, all hearts lit
		assign p1Heart[j] = inHeart(drawX, drawY, HEART1_X[j]);

		// snake 2 heart j needs MAX_HEALTH-j lives
		// so the leftmost one drops out first
		assign p2Heart[j] = inHeart(drawX, drawY, HEART2_X[j]) &&
			(int'(snake2Health) >= MAX_HEALTH - j);
	end

	assign heartOn = (|p1Heart) || (|p2Heart);

endmodule

/* hw/pixelCompositor.sv */
`timescale 1ns/1ps

module pixelCompositor import snakeArenaPkg::*; (
	input  logic       vga_clk,
	input  logic       rstN,
	input  logic       blank,
	input  pixelColor  bgPixel,
	input  pixelColor  snake1Pixel,
	input  pixelColor  snake2Pixel,
	input  logic       snake1On,
	input  logic       snake2On,
	input  logic       venomOn,
	input  logic       heartOn,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue
);

	pixelColor nextPix;
	pixelColor outPix;

	// layer priority, top first
	always_comb begin
		if (!blank) begin
			// outside visible area
			nextPix.raw = '0;
		end else if (heartOn) begin
			// hearts sit above everything
			nextPix.raw = HEART_COLOR;
		end else if (venomOn) begin
			nextPix.raw = VENOM_COLOR;
		end else if (snake1On) begin
			// snake 1 covers snake 2 where heads overlap
			nextPix = snake1Pixel;
		end else if (snake2On) begin
			nextPix = snake2Pixel;
		end else begin
			nextPix = bgPixel;
		end
	end

	// one pixel of latency to the DAC
	always_ff @(posedge vga_clk or negedge rstN) begin
		if (!rstN) begin
			outPix.raw <= '0;
		end else begin
			outPix <= nextPix;
		end
	end

	// split into channels
	assign red = outPix.ch.red;
	assign green = outPix.ch.green;
	assign blue = outPix.ch.blue;

endmodule

/* hw/snakeArenaPkg.sv */
package snakeArenaPkg;

	// raster coordinate, covers 0..1023
	typedef logic [9:0] coordT;

	// remaining lives of snake 2
	typedef logic [1:0] healthT;

	// one 12-bit colour word
	// channel view for the rgb outputs, raw view for key and constant compares
	typedef union packed {
		struct packed {
			logic [3:0] red;
			logic [3:0] green;
			logic [3:0] blue;
		} ch;
		logic [11:0] raw;
	} pixelColor;

	// head box spans pos-12 .. pos+11 on both axes
	localparam int SPRITE_HALF = 12;

	// magenta marks see-through sprite pixels
	localparam logic [11:0] TRANSPARENT_KEY = 12'hF0F;

	// heart box spans centre-8 .. centre+8
	localparam int HEART_HALF = 8;

	// hearts sit on one row near the bottom edge
	localparam coordT HEART_ROW_Y = 10'd470;

	// snake 1 hearts, bottom left
	localparam coordT HEART1_X [3] = '{10'd13, 10'd28, 10'd43};

	// snake 2 hearts, bottom right
	// leftmost one goes out first
	localparam coordT HEART2_X [3] = '{10'd597, 10'd612, 10'd627};

	// solid red hearts
	localparam logic [11:0] HEART_COLOR = 12'hF00;

	// venom drawn black
	localparam logic [11:0] VENOM_COLOR = 12'h000;

endpackage

/* hw/snakeArenaTop.sv */
`timescale 1ns/1ps

module snakeArenaTop import snakeArenaPkg::*; #(
	parameter int NUM_VENOMS = 3,
	parameter int MAX_HEALTH = 3
) (
	input  logic       vga_clk,
	input  logic       rstN,
	input  coordT      drawX,
	input  coordT      drawY,
	input  logic       blank,
	input  coordT      snake1X,
	input  coordT      snake1Y,
	input  coordT      snake2X,
	input  coordT      snake2Y,
	input  coordT      venomX [NUM_VENOMS],
	input  coordT      venomY [NUM_VENOMS],
	input  coordT      venomR [NUM_VENOMS],
	input  logic [NUM_VENOMS-1:0] venomActive,
	input  pixelColor  bgPixel,
	input  pixelColor  snake1Pixel,
	input  pixelColor  snake2Pixel,
	output logic [3:0] red,
	output logic [3:0] green,
	output logic [3:0] blue,
	output healthT     snake2Health,
	output logic       snake1Won
);

	logic snake1On;
	logic snake2On;
	logic [NUM_VENOMS-1:0] venomOn;
	logic heartOn;

	// combinational hit flags for the current pixel
	spriteHitTest #(
		.NUM_VENOMS(NUM_VENOMS)
	) i_spriteHitTest (
		.drawX(drawX), .drawY(drawY),
		.snake1X(snake1X), .snake1Y(snake1Y),
		.snake2X(snake2X), .snake2Y(snake2Y),
		.venomX(venomX), .venomY(venomY), .venomR(venomR),
		.venomActive(venomActive),
		.snake1Pixel(snake1Pixel), .snake2Pixel(snake2Pixel),
		.snake1On(snake1On), .snake2On(snake2On), .venomOn(venomOn)
	);

	// any venom counts as a hit on snake 2
	healthTracker #(
		.MAX_HEALTH(MAX_HEALTH)
	) i_healthTracker (
		.vga_clk(vga_clk), .rstN(rstN),
		.drawX(drawX), .drawY(drawY),
		.snake2On(snake2On), .venomOn(|venomOn),
		.snake2Health(snake2Health), .snake1Won(snake1Won)
	);

	heartOverlay #(
		.MAX_HEALTH(MAX_HEALTH)
	) i_heartOverlay (
		.drawX(drawX), .drawY(drawY),
		.snake2Health(snake2Health), .heartOn(heartOn)
	);

	// registered rgb out
	pixelCompositor i_pixelCompositor (
		.vga_clk(vga_clk), .rstN(rstN), .blank(blank),
		.bgPixel(bgPixel), .snake1Pixel(snake1Pixel), .snake2Pixel(snake2Pixel),
		.snake1On(snake1On), .snake2On(snake2On), .venomOn(|venomOn), .heartOn(heartOn),
		.red(red), .green(green), .blue(blue)
	);

endmodule

/* hw/spriteHitTest.sv */
`timescale 1ns/1ps

module spriteHitTest import snakeArenaPkg::*; #(
	parameter int NUM_VENOMS = 3
) (
	input  coordT     drawX,
	input  coordT     drawY,
	input  coordT     snake1X,
	input  coordT     snake1Y,
	input  coordT     snake2X,
	input  coordT     snake2Y,
	input  coordT     venomX [NUM_VENOMS],
	input  coordT     venomY [NUM_VENOMS],
	input  coordT     venomR [NUM_VENOMS],
	input  logic [NUM_VENOMS-1:0] venomActive,
	input  pixelColor snake1Pixel,
	input  pixelColor snake2Pixel,
	output logic      snake1On,
	output logic      snake2On,
	output logic [NUM_VENOMS-1:0] venomOn
);

	// head box test plus transparency key
	// signed offsets so heads near the screen edge do not wrap
	function automatic logic headHit(coordT px, coordT py, coordT cx, coordT cy,
		pixelColor pix);
		logic signed [10:0] dx;
		logic signed [10:0] dy;
		dx = $signed({1'b0, px}) - $signed({1'b0, cx});
		dy = $signed({1'b0, py}) - $signed({1'b0, cy});
		return (dx >= -SPRITE_HALF) && (dx < SPRITE_HALF) &&
			(dy >= -SPRITE_HALF) && (dy < SPRITE_HALF) &&
			(pix.raw != TRANSPARENT_KEY);
	endfunction

	assign snake1On = headHit(drawX, drawY, snake1X, snake1Y, snake1Pixel);
	assign snake2On = headHit(drawX, drawY, snake2X, snake2Y, snake2Pixel);

	// one circle test per venom
	for (genvar i = 0; i < NUM_VENOMS; i++) begin : gVenom
		logic signed [21:0] dx;
		logic signed [21:0] dy;
		logic [21:0] distSq;
		logic [21:0] radSq;

		// offsets from the venom centre, sign extended wide enough for the square
		assign dx = $signed({12'b0, drawX}) - $signed({12'b0, venomX[i]});
		assign dy = $signed({12'b0, drawY}) - $signed({12'b0, venomY[i]});

		// max sum is 2*1023^2, still below 2^21
		assign distSq = dx * dx + dy * dy;
		assign radSq = {12'b0, venomR[i]} * {12'b0, venomR[i]};

		// rim pixels count as inside
		assign venomOn[i] = venomActive[i] && (distSq <= radSq);
	end

endmodule

/* src.f */
hw/snakeArenaPkg.sv
hw/spriteHitTest.sv
hw/healthTracker.sv
hw/heartOverlay.sv
hw/pixelCompositor.sv
hw/snakeArenaTop.sv
dv/snakeArena_assertions.sv
dv/snakeArenaChecker.sv
dv/snakeArenaTb.sv
